//--- design/cache_pkg.sv
package cache_pkg;

	// geometry
	localparam int ADDR_W          = 32; // word address
	localparam int WORD_W          = 32;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int OFFSET_W        = 2;
	localparam int SET_COUNT       = 16;
	localparam int INDEX_W         = 4;
	localparam int TAG_W           = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [ADDR_W-1:0]                 addr_t;
	typedef logic [WORD_W-1:0]                 word_t;
	typedef logic [TAG_W-1:0]                  tag_t;
	typedef logic [INDEX_W-1:0]                index_t;
	typedef logic [OFFSET_W-1:0]               offset_t;
	typedef logic [WORDS_PER_BLOCK*WORD_W-1:0] block_t; // word 0 in the low bits

	// one tag RAM entry per way and set
	typedef struct packed {
		logic valid;
		logic used;  // most recently used way of the set
		logic dirty;
		tag_t tag;
	} tag_entry_t;

endpackage

//--- design/set_ram.sv
`timescale 1ns/1ns

// one entry per set, async read
module set_ram #(
	parameter type entry_t = logic
) (
	input  logic              clk,
	input  logic              reset,
	input  cache_pkg::index_t index,
	input  logic              we,
	input  entry_t            wr,
	output entry_t            rd
);

	entry_t mem [cache_pkg::SET_COUNT];

	// small array, so reset can clear every entry
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < cache_pkg::SET_COUNT; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[index] <= wr;
		end
	end

	assign rd = mem[index];

endmodule

//--- design/way_select.sv
`timescale 1ns/1ns

module way_select (
	input  cache_pkg::addr_t      req_addr,
	input  cache_pkg::word_t      write_word,
	input  cache_pkg::tag_entry_t tag_rd_0,
	input  cache_pkg::tag_entry_t tag_rd_1,
	input  cache_pkg::block_t     data_rd_0,
	input  cache_pkg::block_t     data_rd_1,
	output logic                  hit,
	output logic                  hit_way,
	output cache_pkg::word_t      hit_word,
	output logic                  victim_way,
	output logic                  victim_dirty,
	output cache_pkg::tag_t       victim_tag,
	output cache_pkg::block_t     victim_block,
	output cache_pkg::block_t     merged_block
);

	cache_pkg::tag_t       req_tag;
	cache_pkg::offset_t    req_offset;
	logic                  hit_0;
	logic                  hit_1;
	cache_pkg::block_t     hit_block;
	cache_pkg::tag_entry_t victim_entry;

	assign req_tag    = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
	assign req_offset = req_addr[cache_pkg::OFFSET_W-1:0];

	// tag compare, only valid entries count
	assign hit_0   = tag_rd_0.valid && (tag_rd_0.tag == req_tag);
	assign hit_1   = tag_rd_1.valid && (tag_rd_1.tag == req_tag);
	assign hit     = hit_0 || hit_1;
	assign hit_way = !hit_0 && hit_1;

	assign hit_block = hit_way ? data_rd_1 : data_rd_0;
	assign hit_word  = hit_block[req_offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];

	// write hit puts the new word in place
	always_comb begin
		merged_block = hit_block;
		merged_block[req_offset*cache_pkg::WORD_W +: cache_pkg::WORD_W] = write_word;
	end

	// replace the way whose used bit is clear, way 0 when both are clear
	assign victim_way   = tag_rd_0.used && !tag_rd_1.used;
	assign victim_entry = victim_way ? tag_rd_1 : tag_rd_0;
	assign victim_dirty = victim_entry.valid && victim_entry.dirty;
	assign victim_tag   = victim_entry.tag;
	assign victim_block = victim_way ? data_rd_1 : data_rd_0;

endmodule

//--- design/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	// processor side
	input  logic                  cpu_req,
	input  logic                  cpu_write,
	input  cache_pkg::addr_t      cpu_addr,
	input  cache_pkg::word_t      cpu_wdata,
	output logic                  cpu_ack,
	output cache_pkg::word_t      cpu_rdata,
	// memory side
	output logic                  mem_req,
	output logic                  mem_write,
	output cache_pkg::addr_t      mem_addr,
	output cache_pkg::word_t      mem_wdata,
	input  logic                  mem_ack,
	input  cache_pkg::word_t      mem_rdata,
	// from way_select
	input  logic                  hit,
	input  logic                  hit_way,
	input  cache_pkg::word_t      hit_word,
	input  logic                  victim_way,
	input  logic                  victim_dirty,
	input  cache_pkg::tag_t       victim_tag,
	input  cache_pkg::block_t     victim_block,
	input  cache_pkg::block_t     merged_block,
	output cache_pkg::addr_t      req_addr,
	output cache_pkg::word_t      write_word,
	// RAM ports
	input  cache_pkg::tag_entry_t tag_rd_0,
	input  cache_pkg::tag_entry_t tag_rd_1,
	output cache_pkg::index_t     ram_index,
	output logic                  tag_we_0,
	output logic                  tag_we_1,
	output logic                  data_we_0,
	output logic                  data_we_1,
	output cache_pkg::tag_entry_t tag_wr_0,
	output cache_pkg::tag_entry_t tag_wr_1,
	output cache_pkg::block_t     data_wr
);

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_writeback,
		st_refill,
		st_fill,
		st_respond
	} state_t;

	state_t                state;
	cache_pkg::offset_t    word_cnt;   // word offset of the current memory transfer
	logic                  req_write;
	cache_pkg::block_t     xfer_block;
	cache_pkg::tag_t       req_tag;
	cache_pkg::tag_entry_t fill_entry;
	logic                  word_done;
	logic                  last_word;

	assign req_tag   = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
	assign ram_index = req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

	assign word_done = mem_req && mem_ack; // memory took or returned the word
	assign last_word = (word_cnt == cache_pkg::offset_t'(cache_pkg::WORDS_PER_BLOCK - 1));

	// all memory fields come from registers, so they hold while mem_req is high
	assign mem_write = (state == st_writeback);
	assign mem_addr  = {(state == st_writeback) ? victim_tag : req_tag, ram_index, word_cnt};
	assign mem_wdata = xfer_block[cache_pkg::WORD_W-1:0];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state    <= st_idle;
			cpu_ack  <= 1'b0;
			mem_req  <= 1'b0;
			word_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (cpu_req)
						state <= st_lookup;
				end
				st_lookup: begin
					word_cnt <= '0;
					if (hit)
						state <= st_respond;
					else if (victim_dirty)
						state <= st_writeback; // old block goes out first
					else
						state <= st_refill;
				end
				st_writeback, st_refill: begin
					if (word_done) begin
						mem_req  <= 1'b0;
						word_cnt <= word_cnt + 1'b1;
						if (last_word)
							state <= (state == st_writeback) ? st_refill : st_fill;
					end else if (!mem_req && !mem_ack) begin
						mem_req <= 1'b1; // previous word fully closed
					end
				end
				st_fill: begin
					state <= st_lookup; // replays the request, now a hit
				end
				st_respond: begin
					if (!cpu_ack) begin
						cpu_ack <= 1'b1;
					end else if (!cpu_req) begin
						cpu_ack <= 1'b0;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request latch and data path
	always_ff @(posedge clk) begin
		if (state == st_idle && cpu_req) begin
			req_addr   <= cpu_addr;
			req_write  <= cpu_write;
			write_word <= cpu_wdata;
		end
		if (state == st_lookup) begin
			if (hit && !req_write)
				cpu_rdata <= hit_word;
			if (!hit)
				xfer_block <= victim_block;
		end
		// low word leaves on write-back, refill words enter at the top
		if (word_done)
			xfer_block <= {mem_rdata, xfer_block[$bits(xfer_block)-1:cache_pkg::WORD_W]};
	end

	always_comb begin
		fill_entry       = '0;
		fill_entry.valid = 1'b1;
		fill_entry.used  = 1'b1;
		fill_entry.tag   = req_tag;
	end

	// RAM writes
	always_comb begin
		tag_wr_0  = tag_rd_0;
		tag_wr_1  = tag_rd_1;
		tag_we_0  = 1'b0;
		tag_we_1  = 1'b0;
		data_we_0 = 1'b0;
		data_we_1 = 1'b0;
		data_wr   = merged_block;
		case (state)
			st_lookup: begin
				if (hit) begin
					tag_we_0      = 1'b1;
					tag_we_1      = 1'b1;
					tag_wr_0.used = !hit_way;
					tag_wr_1.used = hit_way;
					if (req_write) begin
						data_we_0 = !hit_way;
						data_we_1 = hit_way;
						if (hit_way)
							tag_wr_1.dirty = 1'b1;
						else
							tag_wr_0.dirty = 1'b1;
					end
				end
			end
			st_fill: begin
				data_wr   = xfer_block;
				tag_we_0  = 1'b1;
				tag_we_1  = 1'b1;
				data_we_0 = !victim_way;
				data_we_1 = victim_way;
				if (victim_way) begin
					tag_wr_1      = fill_entry;
					tag_wr_0.used = 1'b0;
				end else begin
					tag_wr_0      = fill_entry;
					tag_wr_1.used = 1'b0;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ns

module cache_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             cpu_req,
	input  logic             cpu_write,
	input  cache_pkg::addr_t cpu_addr,
	input  cache_pkg::word_t cpu_wdata,
	output logic             cpu_ack,
	output cache_pkg::word_t cpu_rdata,
	output logic             mem_req,
	output logic             mem_write,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata,
	input  logic             mem_ack,
	input  cache_pkg::word_t mem_rdata
);

	cache_pkg::addr_t      req_addr;
	cache_pkg::word_t      write_word;
	cache_pkg::index_t     ram_index;

	// lookup results
	logic                  hit;
	logic                  hit_way;
	cache_pkg::word_t      hit_word;
	logic                  victim_way;
	logic                  victim_dirty;
	cache_pkg::tag_t       victim_tag;
	cache_pkg::block_t     victim_block;
	cache_pkg::block_t     merged_block;

	// RAM read and write sides
	cache_pkg::tag_entry_t tag_rd_0;
	cache_pkg::tag_entry_t tag_rd_1;
	cache_pkg::tag_entry_t tag_wr_0;
	cache_pkg::tag_entry_t tag_wr_1;
	cache_pkg::block_t     data_rd_0;
	cache_pkg::block_t     data_rd_1;
	cache_pkg::block_t     data_wr;
	logic                  tag_we_0;
	logic                  tag_we_1;
	logic                  data_we_0;
	logic                  data_we_1;

	cache_ctrl cache_ctrl_i (
		.clk          (clk),
		.reset        (reset),
		.cpu_req      (cpu_req),
		.cpu_write    (cpu_write),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_ack      (cpu_ack),
		.cpu_rdata    (cpu_rdata),
		.mem_req      (mem_req),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_ack      (mem_ack),
		.mem_rdata    (mem_rdata),
		.hit          (hit),
		.hit_way      (hit_way),
		.hit_word     (hit_word),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_block (victim_block),
		.merged_block (merged_block),
		.req_addr     (req_addr),
		.write_word   (write_word),
		.tag_rd_0     (tag_rd_0),
		.tag_rd_1     (tag_rd_1),
		.ram_index    (ram_index),
		.tag_we_0     (tag_we_0),
		.tag_we_1     (tag_we_1),
		.data_we_0    (data_we_0),
		.data_we_1    (data_we_1),
		.tag_wr_0     (tag_wr_0),
		.tag_wr_1     (tag_wr_1),
		.data_wr      (data_wr)
	);

	way_select way_select_i (
		.req_addr     (req_addr),
		.write_word   (write_word),
		.tag_rd_0     (tag_rd_0),
		.tag_rd_1     (tag_rd_1),
		.data_rd_0    (data_rd_0),
		.data_rd_1    (data_rd_1),
		.hit          (hit),
		.hit_way      (hit_way),
		.hit_word     (hit_word),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_block (victim_block),
		.merged_block (merged_block)
	);

	// tag RAMs, one per way
	set_ram #(.entry_t(cache_pkg::tag_entry_t)) tag_ram_0 (
		.clk   (clk),
		.reset (reset),
		.index (ram_index),
		.we    (tag_we_0),
		.wr    (tag_wr_0),
		.rd    (tag_rd_0)
	);

	set_ram #(.entry_t(cache_pkg::tag_entry_t)) tag_ram_1 (
		.clk   (clk),
		.reset (reset),
		.index (ram_index),
		.we    (tag_we_1),
		.wr    (tag_wr_1),
		.rd    (tag_rd_1)
	);

	// data RAMs share the write block
	set_ram #(.entry_t(cache_pkg::block_t)) data_ram_0 (
		.clk   (clk),
		.reset (reset),
		.index (ram_index),
		.we    (data_we_0),
		.wr    (data_wr),
		.rd    (data_rd_0)
	);

	set_ram #(.entry_t(cache_pkg::block_t)) data_ram_1 (
		.clk   (clk),
		.reset (reset),
		.index (ram_index),
		.we    (data_we_1),
		.wr    (data_wr),
		.rd    (data_rd_1)
	);

endmodule

//--- tb/mem_model.sv
`timescale 1ns/1ns

// word-wide main memory, one four-phase req/ack per word
module mem_model #(
	parameter cache_pkg::word_t FILL_XOR = 32'h5a5a_0000
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             mem_req,
	input  logic             mem_write,
	input  cache_pkg::addr_t mem_addr,
	input  cache_pkg::word_t mem_wdata,
	output logic             mem_ack,
	output cache_pkg::word_t mem_rdata,
	output int               read_count,
	output int               write_count
);

	cache_pkg::word_t words [cache_pkg::addr_t]; // only written words live here
	integer           seed = 32'h73ae_fa5c;
	int               delay;

	initial begin
		mem_ack     = 1'b0;
		mem_rdata   = '0;
		read_count  = 0;
		write_count = 0;
		forever begin
			@(posedge clk);
			if (reset && mem_req && !mem_ack) begin
				delay = $unsigned($random(seed)) % 4; // 0 to 3 cycles
				repeat (delay) @(posedge clk);
				if (mem_write) begin
					words[mem_addr] = mem_wdata;
					write_count++;
				end else begin
					if (words.exists(mem_addr))
						mem_rdata <= words[mem_addr];
					else
						mem_rdata <= mem_addr ^ FILL_XOR; // untouched word
					read_count++;
				end
				mem_ack <= 1'b1;
				while (mem_req)
					@(posedge clk);
				mem_ack <= 1'b0; // req seen low
			end
		end
	end

endmodule

//--- tb/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

	localparam cache_pkg::word_t FILL_XOR = 32'h5a5a_0000;
	// about 120 transactions at a worst case near 60 cycles leave wide margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int HIT_CYCLES     = 4; // drive edge to the edge that samples cpu_ack

	logic             clk;
	logic             reset;
	logic             cpu_req;
	logic             cpu_write;
	cache_pkg::addr_t cpu_addr;
	cache_pkg::word_t cpu_wdata;
	logic             cpu_ack;
	cache_pkg::word_t cpu_rdata;
	logic             mem_req;
	logic             mem_write;
	cache_pkg::addr_t mem_addr;
	cache_pkg::word_t mem_wdata;
	logic             mem_ack;
	cache_pkg::word_t mem_rdata;
	int               read_count;
	int               write_count;

	cache_pkg::word_t   shadow [cache_pkg::addr_t]; // processor view of memory
	integer             seed = 32'h73ae_fa5c;
	int                 cycle_count = 0;
	int                 latency; // cycles of the last access
	cache_pkg::offset_t mem_offset = '0; // offset the next memory word must carry

	cache_top cache_top_i (
		.clk       (clk),
		.reset     (reset),
		.cpu_req   (cpu_req),
		.cpu_write (cpu_write),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.mem_req   (mem_req),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	mem_model #(.FILL_XOR(FILL_XOR)) mem_model_i (
		.clk         (clk),
		.reset       (reset),
		.mem_req     (mem_req),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.read_count  (read_count),
		.write_count (write_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a handshake never completed", cycle_count);
			$display("Verification failed");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	function automatic cache_pkg::addr_t make_addr(
		input cache_pkg::tag_t    tag,
		input cache_pkg::index_t  index,
		input cache_pkg::offset_t offset
	);
		return {tag, index, offset};
	endfunction

	function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return addr ^ FILL_XOR; // never written
	endfunction

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("error: time %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("Verification failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// each memory word completes at the one edge where mem_req and mem_ack are both high
	always @(posedge clk) begin
		if (mem_req && mem_ack) begin
			check_equal("mem_addr offset", mem_offset, mem_addr[cache_pkg::OFFSET_W-1:0]);
			if (mem_write)
				check_equal("mem_wdata", expected_word(mem_addr), mem_wdata); // dirty word out
			mem_offset = mem_offset + 1'b1;
		end
	end

	// one four-phase processor transaction started on a rising edge
	task automatic cpu_access(input logic write, input cache_pkg::addr_t addr,
			input cache_pkg::word_t wdata, output cache_pkg::word_t rdata);
		cpu_req   <= 1'b1;
		cpu_write <= write;
		cpu_addr  <= addr;
		cpu_wdata <= wdata;
		latency = 0;
		do begin
			@(posedge clk);
			latency++;
		end while (!cpu_ack);
		rdata = cpu_rdata;
		cpu_req <= 1'b0;
		do
			@(posedge clk);
		while (cpu_ack);
		if (write)
			shadow[addr] = wdata;
	endtask

	task automatic cold_read_miss();
		cache_pkg::addr_t addr;
		cache_pkg::word_t data;
		int               reads;
		addr  = make_addr(26'h1, 4'h3, 2'd1);
		reads = read_count;
		cpu_access(1'b0, addr, '0, data);
		check_equal("cpu_rdata", expected_word(addr), data);
		check_equal("read_count", reads + 4, read_count); // one block refill
	endtask

	task automatic read_hit();
		cache_pkg::addr_t addr;
		cache_pkg::word_t data;
		int               reads;
		int               writes;
		reads  = read_count;
		writes = write_count;
		for (int off = 0; off < cache_pkg::WORDS_PER_BLOCK; off++) begin
			addr = make_addr(26'h1, 4'h3, cache_pkg::offset_t'(off));
			cpu_access(1'b0, addr, '0, data);
			check_equal("cpu_rdata", expected_word(addr), data);
			check_equal("hit latency", HIT_CYCLES, latency);
		end
		check_equal("read_count", reads, read_count);
		check_equal("write_count", writes, write_count);
	endtask

	task automatic write_hit_read();
		cache_pkg::addr_t addr;
		cache_pkg::word_t data;
		int               reads;
		int               writes;
		addr   = make_addr(26'h1, 4'h3, 2'd2);
		reads  = read_count;
		writes = write_count;
		cpu_access(1'b1, addr, 32'hdead_beef, data);
		cpu_access(1'b0, addr, '0, data);
		check_equal("cpu_rdata", 32'hdead_beef, data);
		check_equal("read_count", reads, read_count);
		check_equal("write_count", writes, write_count); // stays in the cache
	endtask

	task automatic lru_dirty_evict();
		cache_pkg::addr_t a;
		cache_pkg::addr_t b;
		cache_pkg::addr_t c;
		cache_pkg::addr_t d;
		cache_pkg::word_t data;
		int               reads;
		int               writes;
		a = make_addr(26'h10, 4'h7, 2'd2);
		b = make_addr(26'h20, 4'h7, 2'd0);
		c = make_addr(26'h30, 4'h7, 2'd1);
		d = make_addr(26'h40, 4'h7, 2'd3);
		cpu_access(1'b1, a, 32'h1234_5678, data);
		cpu_access(1'b0, b, '0, data);
		check_equal("cpu_rdata", expected_word(b), data);
		cpu_access(1'b0, a, '0, data); // A most recently used
		check_equal("cpu_rdata", 32'h1234_5678, data);
		writes = write_count;
		cpu_access(1'b0, c, '0, data); // clean B is the victim
		check_equal("cpu_rdata", expected_word(c), data);
		check_equal("write_count", writes, write_count);
		cpu_access(1'b0, d, '0, data); // dirty A is the victim
		check_equal("cpu_rdata", expected_word(d), data);
		check_equal("write_count", writes + 4, write_count);
		reads = read_count;
		cpu_access(1'b0, a, '0, data);
		check_equal("cpu_rdata", 32'h1234_5678, data);
		check_equal("read_count", reads + 4, read_count);
	endtask

	task automatic random_traffic();
		cache_pkg::addr_t addr;
		cache_pkg::word_t data;
		cache_pkg::word_t wdata;
		logic             write;
		int               tag_sel;
		int               set_sel;
		int               off_sel;
		for (int i = 0; i < 100; i++) begin
			tag_sel = $unsigned($random(seed)) % 3;
			set_sel = $unsigned($random(seed)) % 2;
			off_sel = $unsigned($random(seed)) % 4;
			write   = ($unsigned($random(seed)) % 2) == 1;
			wdata   = $random(seed);
			addr    = make_addr(cache_pkg::tag_t'(26'h100 + tag_sel),
				cache_pkg::index_t'(set_sel), cache_pkg::offset_t'(off_sel));
			if (write) begin
				cpu_access(1'b1, addr, wdata, data);
			end else begin
				cpu_access(1'b0, addr, '0, data);
				check_equal("cpu_rdata", expected_word(addr), data);
			end
		end
	endtask

	initial begin
		reset     <= 1'b0;
		cpu_req   <= 1'b0;
		cpu_write <= 1'b0;
		cpu_addr  <= '0;
		cpu_wdata <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		check_equal("cpu_ack", 1'b0, cpu_ack);
		check_equal("mem_req", 1'b0, mem_req);
		cold_read_miss();
		read_hit();
		write_hit_read();
		lru_dirty_evict();
		random_traffic();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- cache_top.f
design/cache_pkg.sv
design/set_ram.sv
design/way_select.sv
design/cache_ctrl.sv
design/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv
